/* hw/icache_pkg.sv */
// shared sizes, address split and enums for the two-way instruction cache
// sizes are fixed here, the two-way structure is not configurable
`default_nettype none

package icache_pkg;

    // fetch address and block geometry
    localparam int addr_width  = 32;
    localparam int block_bits  = 64;
    localparam int num_sets    = 16;

    // address split: tag | index | byte offset
    localparam int offset_bits = 3;
    localparam int index_bits  = 4;
    localparam int tag_bits    = addr_width - index_bits - offset_bits;

    // fetch unit starts with this many credits after reset
    localparam int fetch_credits = 1;

    // width of the memory credit counter, one refill in flight at a time
    localparam int mem_credit_bits = 2;

    // fetch port opcodes
    typedef enum logic [0:0] {
        op_fetch = 1'b0,
        op_flush = 1'b1
    } req_op_e;

    // miss and flush controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wait_credit,
        st_wait_mem,
        st_fill,
        st_replay,
        st_flush
    } refill_state_e;

endpackage

`default_nettype wire

/* hw/icache_way.sv */
// one cache way: valid bits, tag array and data array behind a registered read port
// a write sets the valid bit, a clear drops one set's valid bit
`timescale 1ns/1ps
`default_nettype none

module icache_way (
    input  logic                               clk,
    input  logic                               rst_n,
    // read side, data shows up one cycle after the index
    input  logic [icache_pkg::index_bits-1:0]  rd_index,
    // refill write
    input  logic                               wr_en,
    input  logic [icache_pkg::index_bits-1:0]  wr_index,
    input  logic [icache_pkg::tag_bits-1:0]    wr_tag,
    input  logic [icache_pkg::block_bits-1:0]  wr_data,
    // flush walk
    input  logic                               clear_en,
    input  logic [icache_pkg::index_bits-1:0]  clear_index,
    // registered read outputs
    output logic                               rd_valid,
    output logic [icache_pkg::tag_bits-1:0]    rd_tag,
    output logic [icache_pkg::block_bits-1:0]  rd_data
);

    // per-set valid bits live in flops so reset and flush can clear them
    logic [icache_pkg::num_sets-1:0]   valid_q;

    // tag and data storage, no reset needed
    logic [icache_pkg::tag_bits-1:0]   tag_mem  [icache_pkg::num_sets];
    logic [icache_pkg::block_bits-1:0] data_mem [icache_pkg::num_sets];

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            // clear first so a write to the same set wins
            if (clear_en) begin
                valid_q[clear_index] <= 1'b0;
            end
            if (wr_en) begin
                valid_q[wr_index] <= 1'b1;
            end
        end
    end

    // tag and block arrays, written on a refill
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
    end

    // registered read of the valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= valid_q[rd_index];
        end
    end

    // registered read of tag and block
    // a same-edge write is seen one cycle later
    always_ff @(posedge clk) begin
        rd_tag  <= tag_mem[rd_index];
        rd_data <= data_mem[rd_index];
    end

endmodule

`default_nettype wire

/* hw/icache_way_select.sv */
// tag compare and one-hot way select over the two registered way outputs
// keeps one lru bit per set, the bit names the way to replace next
`timescale 1ns/1ps
`default_nettype none

module icache_way_select (
    input  logic                               clk,
    input  logic                               rst_n,
    // address being looked up, held by the controller
    input  logic [icache_pkg::tag_bits-1:0]    lookup_tag,
    input  logic [icache_pkg::index_bits-1:0]  lookup_index,
    // way 0 read port
    input  logic                               way0_valid,
    input  logic [icache_pkg::tag_bits-1:0]    way0_tag,
    input  logic [icache_pkg::block_bits-1:0]  way0_data,
    // way 1 read port
    input  logic                               way1_valid,
    input  logic [icache_pkg::tag_bits-1:0]    way1_tag,
    input  logic [icache_pkg::block_bits-1:0]  way1_data,
    // lru update strobes from the controller
    input  logic                               touch_en,
    input  logic                               fill_en,
    input  logic                               fill_way,
    output logic                               hit,
    output logic                               hit_way,
    output logic [icache_pkg::block_bits-1:0]  sel_data,
    output logic                               victim_way
);

    logic way0_match;
    logic way1_match;
    logic way0_sel;
    logic way1_sel;

    // lru bit per set, 0 means way 0 is the next victim
    logic [icache_pkg::num_sets-1:0] lru_q;

    // raw tag compares
    assign way0_match = (way0_tag == lookup_tag);
    assign way1_match = (way1_tag == lookup_tag);

    // a match only counts with its valid bit
    assign way0_sel = way0_match & way0_valid;
    assign way1_sel = way1_match & way1_valid;

    assign hit     = way0_sel | way1_sel;
    assign hit_way = way1_sel;

    // one-hot and-or mux over the two blocks
    assign sel_data = ({icache_pkg::block_bits{way0_sel}} & way0_data) |
                      ({icache_pkg::block_bits{way1_sel}} & way1_data);

    // empty way first, way 0 before way 1, then the lru way
    always_comb begin
        if (!way0_valid) begin
            victim_way = 1'b0;
        end else if (!way1_valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[lookup_index];
        end
    end

    // used way becomes most recent, so the bit points at the other one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (fill_en) begin
            lru_q[lookup_index] <= ~fill_way;
        end else if (touch_en) begin
            lru_q[lookup_index] <= ~hit_way;
        end
    end

endmodule

`default_nettype wire

/* hw/icache_refill.sv */
// miss and flush controller, one fetch or flush in flight at a time
// hit answers two cycles after the request, a miss replays after the fill
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  logic                                clk,
    input  logic                                rst_n,
    // fetch port
    input  logic                                req_valid,
    input  icache_pkg::req_op_e                 req_op,
    input  logic [icache_pkg::addr_width-1:0]   req_addr,
    // from the selector
    input  logic                                hit,
    input  logic                                victim_way,
    // memory port
    input  logic                                mem_credit,
    input  logic                                mem_resp_valid,
    input  logic [icache_pkg::block_bits-1:0]   mem_resp_data,
    // lookup address into both ways and the selector
    output logic [icache_pkg::tag_bits-1:0]     lookup_tag,
    output logic [icache_pkg::index_bits-1:0]   lookup_index,
    // lru strobes
    output logic                                touch_en,
    output logic                                fill_en,
    output logic                                fill_way,
    // way write and flush controls
    output logic                                wr_en0,
    output logic                                wr_en1,
    output logic [icache_pkg::block_bits-1:0]   wr_data,
    output logic                                clear_en,
    output logic [icache_pkg::index_bits-1:0]   clear_index,
    // response and credit return
    output logic                                resp_valid,
    output logic                                resp_hit,
    output logic                                fetch_credit,
    output logic                                mem_req_valid,
    output logic [icache_pkg::addr_width-1:0]   mem_req_addr
);

    icache_pkg::refill_state_e state_q;
    icache_pkg::refill_state_e state_d;

    // block address of the request, offset bits dropped
    logic [icache_pkg::addr_width-icache_pkg::offset_bits-1:0] blk_addr_q;

    // second cycle of a lookup or replay, way outputs are valid then
    logic                                     cmp_q;
    logic                                     victim_q;
    logic [icache_pkg::block_bits-1:0]        fill_data_q;
    logic [icache_pkg::mem_credit_bits-1:0]   mem_cnt_q;
    // msb set means all sets were cleared
    logic [icache_pkg::index_bits:0]          flush_cnt_q;
    logic                                     in_read;
    logic                                     flush_done;

    assign lookup_tag   = blk_addr_q[icache_pkg::index_bits +: icache_pkg::tag_bits];
    assign lookup_index = blk_addr_q[icache_pkg::index_bits-1:0];
    assign mem_req_addr = {blk_addr_q, {icache_pkg::offset_bits{1'b0}}};

    assign in_read    = (state_q == icache_pkg::st_lookup) || (state_q == icache_pkg::st_replay);
    assign flush_done = flush_cnt_q[icache_pkg::index_bits];

    // first lookup answers only on a hit, the replay always answers
    assign resp_valid = cmp_q && (((state_q == icache_pkg::st_lookup) && hit) ||
                                  (state_q == icache_pkg::st_replay));
    assign resp_hit   = (state_q == icache_pkg::st_lookup);
    assign touch_en   = cmp_q && (state_q == icache_pkg::st_lookup) && hit;

    // fill writes the victim way and moves its lru bit
    assign fill_en  = (state_q == icache_pkg::st_fill);
    assign fill_way = victim_q;
    assign wr_en0   = fill_en && !victim_q;
    assign wr_en1   = fill_en && victim_q;
    assign wr_data  = fill_data_q;

    // flush walks set 0 up to the last, then returns the credit
    assign clear_en     = (state_q == icache_pkg::st_flush) && !flush_done;
    assign clear_index  = flush_cnt_q[icache_pkg::index_bits-1:0];
    assign fetch_credit = resp_valid || ((state_q == icache_pkg::st_flush) && flush_done);

    // one-cycle request, only with a credit in hand
    assign mem_req_valid = (state_q == icache_pkg::st_wait_credit) && (mem_cnt_q != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::st_idle: begin
                if (req_valid) begin
                    if (req_op == icache_pkg::op_flush) begin
                        state_d = icache_pkg::st_flush;
                    end else begin
                        state_d = icache_pkg::st_lookup;
                    end
                end
            end
            icache_pkg::st_lookup: begin
                if (cmp_q) begin
                    state_d = hit ? icache_pkg::st_idle : icache_pkg::st_wait_credit;
                end
            end
            icache_pkg::st_wait_credit: begin
                if (mem_req_valid) begin
                    state_d = icache_pkg::st_wait_mem;
                end
            end
            icache_pkg::st_wait_mem: begin
                if (mem_resp_valid) begin
                    state_d = icache_pkg::st_fill;
                end
            end
            icache_pkg::st_fill:   state_d = icache_pkg::st_replay;
            icache_pkg::st_replay: begin
                if (cmp_q) begin
                    state_d = icache_pkg::st_idle;
                end
            end
            icache_pkg::st_flush: begin
                if (flush_done) begin
                    state_d = icache_pkg::st_idle;
                end
            end
            default: state_d = icache_pkg::st_idle;
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= icache_pkg::st_idle;
            cmp_q       <= 1'b0;
            victim_q    <= 1'b0;
            flush_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            cmp_q   <= in_read && !cmp_q;
            // victim is sampled on the compare cycle of a miss
            if (cmp_q && (state_q == icache_pkg::st_lookup) && !hit) begin
                victim_q <= victim_way;
            end
            if (state_q == icache_pkg::st_flush) begin
                flush_cnt_q <= flush_cnt_q + 1'b1;
            end else begin
                flush_cnt_q <= '0;
            end
        end
    end

    // memory credits: +1 per credit pulse, -1 per request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_cnt_q <= '0;
        end else begin
            case ({mem_credit, mem_req_valid})
                2'b10:   mem_cnt_q <= mem_cnt_q + 1'b1;
                2'b01:   mem_cnt_q <= mem_cnt_q - 1'b1;
                default: mem_cnt_q <= mem_cnt_q;
            endcase
        end
    end

    // request address and returned block
    always_ff @(posedge clk) begin
        if ((state_q == icache_pkg::st_idle) && req_valid) begin
            blk_addr_q <= req_addr[icache_pkg::addr_width-1:icache_pkg::offset_bits];
        end
        if ((state_q == icache_pkg::st_wait_mem) && mem_resp_valid) begin
            fill_data_q <= mem_resp_data;
        end
    end

endmodule

`default_nettype wire

/* hw/icache_top.sv */
// two-way instruction cache, credit-based fetch and memory ports
// one request in flight, blocks are whole 64-bit words with no word select
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                               clk,
    input  logic                               rst_n,
    // fetch port
    input  logic                               req_valid,
    input  icache_pkg::req_op_e                req_op,
    input  logic [icache_pkg::addr_width-1:0]  req_addr,
    output logic                               fetch_credit,
    output logic                               resp_valid,
    output logic                               resp_hit,
    output logic [icache_pkg::block_bits-1:0]  resp_data,
    // backing memory port
    input  logic                               mem_credit,
    output logic                               mem_req_valid,
    output logic [icache_pkg::addr_width-1:0]  mem_req_addr,
    input  logic                               mem_resp_valid,
    input  logic [icache_pkg::block_bits-1:0]  mem_resp_data
);

    // lookup address from the controller
    logic [icache_pkg::tag_bits-1:0]    lookup_tag;
    logic [icache_pkg::index_bits-1:0]  lookup_index;

    // way read outputs
    logic                               way0_valid;
    logic [icache_pkg::tag_bits-1:0]    way0_tag;
    logic [icache_pkg::block_bits-1:0]  way0_data;
    logic                               way1_valid;
    logic [icache_pkg::tag_bits-1:0]    way1_tag;
    logic [icache_pkg::block_bits-1:0]  way1_data;

    // selector results
    logic                               hit;
    logic                               victim_way;

    // write, flush and lru controls
    logic                               wr_en0;
    logic                               wr_en1;
    logic [icache_pkg::block_bits-1:0]  wr_data;
    logic                               clear_en;
    logic [icache_pkg::index_bits-1:0]  clear_index;
    logic                               touch_en;
    logic                               fill_en;
    logic                               fill_way;

    // both ways read and write at the lookup index
    icache_way i_way0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_index    (lookup_index),
        .wr_en       (wr_en0),
        .wr_index    (lookup_index),
        .wr_tag      (lookup_tag),
        .wr_data     (wr_data),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .rd_valid    (way0_valid),
        .rd_tag      (way0_tag),
        .rd_data     (way0_data)
    );

    icache_way i_way1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_index    (lookup_index),
        .wr_en       (wr_en1),
        .wr_index    (lookup_index),
        .wr_tag      (lookup_tag),
        .wr_data     (wr_data),
        .clear_en    (clear_en),
        .clear_index (clear_index),
        .rd_valid    (way1_valid),
        .rd_tag      (way1_tag),
        .rd_data     (way1_data)
    );

    // hit_way only steers the lru update inside the selector
    icache_way_select i_way_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_tag   (lookup_tag),
        .lookup_index (lookup_index),
        .way0_valid   (way0_valid),
        .way0_tag     (way0_tag),
        .way0_data    (way0_data),
        .way1_valid   (way1_valid),
        .way1_tag     (way1_tag),
        .way1_data    (way1_data),
        .touch_en     (touch_en),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .hit          (hit),
        .hit_way      (),
        .sel_data     (resp_data),
        .victim_way   (victim_way)
    );

    icache_refill i_refill (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .hit            (hit),
        .victim_way     (victim_way),
        .mem_credit     (mem_credit),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .lookup_tag     (lookup_tag),
        .lookup_index   (lookup_index),
        .touch_en       (touch_en),
        .fill_en        (fill_en),
        .fill_way       (fill_way),
        .wr_en0         (wr_en0),
        .wr_en1         (wr_en1),
        .wr_data        (wr_data),
        .clear_en       (clear_en),
        .clear_index    (clear_index),
        .resp_valid     (resp_valid),
        .resp_hit       (resp_hit),
        .fetch_credit   (fetch_credit),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr)
    );

endmodule

`default_nettype wire

/* tb/icache_properties.sv */
// credit and handshake rules of icache_top, attached with bind
// tracks both credit counts from the port pulses alone
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input icache_pkg::req_op_e req_op,
    input logic                fetch_credit,
    input logic                resp_valid,
    input logic                mem_credit,
    input logic                mem_req_valid
);

    // failed assertions so far, read by the testbench at the end
    int unsigned assert_fails = 0;

    // memory credits the cache holds
    logic [2:0] mem_cnt_q;
    // fetch credits back at the fetch unit
    logic [1:0] fetch_cnt_q;
    // the outstanding request is a flush
    logic       flush_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_cnt_q   <= '0;
            fetch_cnt_q <= 2'(icache_pkg::fetch_credits);
            flush_q     <= 1'b0;
        end else begin
            if (mem_credit && !mem_req_valid) begin
                mem_cnt_q <= mem_cnt_q + 1'b1;
            end else if (!mem_credit && mem_req_valid) begin
                mem_cnt_q <= mem_cnt_q - 1'b1;
            end
            // request spends a credit, a retire hands it back
            if (req_valid && !fetch_credit) begin
                fetch_cnt_q <= fetch_cnt_q - 1'b1;
            end else if (fetch_credit && !req_valid) begin
                fetch_cnt_q <= fetch_cnt_q + 1'b1;
            end
            if (req_valid) begin
                flush_q <= (req_op == icache_pkg::op_flush);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) mem_req_valid |-> mem_cnt_q != '0)
        else begin
            $error("memory request raised with no memory credit held");
            assert_fails++;
        end

    // no credit comes back that was never spent
    assert property (@(posedge clk) disable iff (!rst_n)
        fetch_credit |-> fetch_cnt_q < 2'(icache_pkg::fetch_credits))
        else begin
            $error("fetch credit returned with no request outstanding");
            assert_fails++;
        end

    // fetch retires with its response and flush retires without one
    assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid || fetch_credit) |-> fetch_credit && (resp_valid == !flush_q))
        else begin
            $error("response and fetch credit do not pair up with the request type");
            assert_fails++;
        end

    assert property (@(posedge clk)
        $rose(rst_n) |-> !resp_valid && !fetch_credit && !mem_req_valid)
        else begin
            $error("outputs not low when reset is released");
            assert_fails++;
        end

endmodule

bind icache_top icache_properties i_icache_properties (.*);

`default_nettype wire

/* tb/icache_tb.sv */
// testbench for icache_top with an lfsr-driven fetch stream, memory responder and cache model
// needs the bound icache_properties instance for its assertion count
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int resp_timeout = 400;
    localparam logic [63:0] data_mask = 64'hA5C3_0F96_5A3C_F069;

    logic                                  clk = 1'b0;
    logic                                  rst_n = 1'b0;
    logic                                  req_valid = 1'b0;
    icache_pkg::req_op_e                   req_op = icache_pkg::op_fetch;
    logic [icache_pkg::addr_width-1:0]     req_addr = '0;
    logic                                  mem_credit = 1'b0;
    logic                                  mem_resp_valid = 1'b0;
    logic [icache_pkg::block_bits-1:0]     mem_resp_data = '0;
    logic                                  fetch_credit;
    logic                                  resp_valid;
    logic                                  resp_hit;
    logic [icache_pkg::block_bits-1:0]     resp_data;
    logic                                  mem_req_valid;
    logic [icache_pkg::addr_width-1:0]     mem_req_addr;

    // separate lfsr states for the fetch stream and the responder
    logic [15:0] rng_q = 16'd24511;
    logic [15:0] mem_rng_q = 16'd24511;
    string       cur_test = "reset";
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    // set once a wait times out, later requests are skipped
    logic        stuck = 1'b0;
    logic        slow_mem = 1'b0;

    // responder state: 0 credit delay, 1 wait request, 2 answer delay
    logic [1:0]  mem_phase;
    int          mem_delay;
    logic        mem_held;
    logic [31:0] mem_addr_q;

    // reference model of tags, valid bits and lru per set
    logic [icache_pkg::tag_bits-1:0] m_tag [2][icache_pkg::num_sets];
    logic                            m_valid [2][icache_pkg::num_sets];
    logic                            m_lru [icache_pkg::num_sets];
    logic [31:0]                     cold_addr [8];

    icache_top i_icache_top (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng_q = lfsr_step(rng_q);
            v = {v[30:0], rng_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            mem_rng_q = lfsr_step(mem_rng_q);
            v = {v[30:0], mem_rng_q[0]};
        end
        return v;
    endfunction

    // memory contents: the block address twice, xored with a mask
    function automatic logic [63:0] block_data(input logic [31:0] a);
        return {a[31:3], 3'b000, a[31:3], 3'b000} ^ data_mask;
    endfunction

    // 4 tags over all 16 sets above a fixed base
    function automatic logic [31:0] small_addr();
        logic [31:0] r;
        r = take_bits(9);
        return {23'h2F_1C03, r[8:0]};
    endfunction

    task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        errors++;
        $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
    endtask

    task automatic give_up(input string what);
        errors++;
        stuck = 1'b1;
        $display("%s: %s", cur_test, what);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test;
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_errors);
        end
    endtask

    // hit updates lru, miss fills an empty way first, else the lru way
    task automatic model_fetch(input logic [31:0] a, output logic hit);
        logic [icache_pkg::index_bits-1:0] idx;
        logic [icache_pkg::tag_bits-1:0]   tag;
        logic                              way;
        idx = a[icache_pkg::offset_bits +: icache_pkg::index_bits];
        tag = a[icache_pkg::addr_width-1 -: icache_pkg::tag_bits];
        hit = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            way = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            way = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : m_lru[idx]);
            m_valid[way][idx] = 1'b1;
            m_tag[way][idx]   = tag;
        end
        m_lru[idx] = ~way;
    endtask

    // one fetch, n counts cycles from the request cycle to the response cycle
    task automatic do_fetch(input logic [31:0] a);
        logic        exp_hit;
        logic        got;
        int          n;
        if (stuck) return;
        model_fetch(a, exp_hit);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= icache_pkg::op_fetch;
        req_addr  <= a;
        @(posedge clk);
        req_valid <= 1'b0;
        n   = 1;
        got = 1'b0;
        while (!got && n < resp_timeout) begin
            @(negedge clk);
            if (resp_valid) begin
                got = 1'b1;
            end else begin
                @(posedge clk);
                n++;
            end
        end
        if (!got) begin
            give_up($sformatf("fetch of %h got no response within %0d cycles", a, n));
            return;
        end
        if (resp_hit !== exp_hit) report_value("resp_hit", exp_hit, resp_hit);
        if (resp_data !== block_data(a)) report_value("resp_data", block_data(a), resp_data);
        if (fetch_credit !== 1'b1) report_value("fetch_credit", 1, fetch_credit);
        if (exp_hit && n != 2) report_value("hit latency", 2, n);
    endtask

    task automatic do_flush;
        logic got;
        int   n;
        if (stuck) return;
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= icache_pkg::op_flush;
        @(posedge clk);
        req_valid <= 1'b0;
        n   = 1;
        got = 1'b0;
        while (!got && n < resp_timeout) begin
            @(negedge clk);
            if (fetch_credit) begin
                got = 1'b1;
            end else begin
                @(posedge clk);
                n++;
            end
        end
        if (!got) begin
            give_up("flush never returned its fetch credit");
            return;
        end
        if (resp_valid) report_value("resp_valid on flush", 0, resp_valid);
        if (n != icache_pkg::num_sets + 1) report_value("flush cycles", icache_pkg::num_sets + 1, n);
        for (int s = 0; s < icache_pkg::num_sets; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
    endtask

    // memory responder: one credit at a time, answers each request after a delay
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_phase <= 2'd0;
            mem_delay <= mem_bits(3);
            mem_held  <= 1'b0;
        end else begin
            mem_credit     <= 1'b0;
            mem_resp_valid <= 1'b0;
            if (mem_req_valid && !mem_held) begin
                errors++;
                $display("%s: memory request raised while no credit was given", cur_test);
            end
            case (mem_phase)
                2'd0: begin
                    if (mem_delay == 0) begin
                        mem_credit <= 1'b1;
                        mem_held   <= 1'b1;
                        mem_phase  <= 2'd1;
                    end else begin
                        mem_delay <= mem_delay - 1;
                    end
                end
                2'd1: begin
                    if (mem_req_valid) begin
                        mem_held   <= 1'b0;
                        mem_addr_q <= mem_req_addr;
                        mem_delay  <= mem_bits(3);
                        mem_phase  <= 2'd2;
                    end
                end
                default: begin
                    if (mem_delay == 0) begin
                        mem_resp_valid <= 1'b1;
                        mem_resp_data  <= block_data(mem_addr_q);
                        mem_phase      <= 2'd0;
                        mem_delay      <= slow_mem ? 8 + mem_bits(5) : mem_bits(3);
                    end else begin
                        mem_delay <= mem_delay - 1;
                    end
                end
            endcase
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] t0;
        int          seq [8];
        int          n_fetch;
        for (int s = 0; s < icache_pkg::num_sets; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        start_test("cold_miss");
        if ({resp_valid, fetch_credit, mem_req_valid} !== 3'b000) begin
            report_value("outputs after reset", 0, {resp_valid, fetch_credit, mem_req_valid});
        end
        // one address per set, all first touches
        for (int i = 0; i < 8; i++) begin
            r = take_bits(25);
            cold_addr[i] = {r[24:0], 4'(i), 3'b000};
            do_fetch(cold_addr[i]);
        end
        end_test();

        start_test("hit_latency");
        for (int i = 0; i < 8; i++) begin
            r = take_bits(3);
            do_fetch({cold_addr[i][31:3], r[2:0]});
        end
        end_test();

        // three tags in set 9, the order forces lru evictions both ways
        start_test("conflict_lru");
        t0  = take_bits(25);
        seq = '{0, 1, 0, 2, 1, 0, 2, 2};
        for (int i = 0; i < 8; i++) begin
            r = t0 ^ seq[i];
            do_fetch({r[24:0], 4'd9, 3'b000});
        end
        end_test();

        start_test("flush");
        do_flush();
        for (int i = 0; i < 8; i++) begin
            do_fetch(cold_addr[i]);
        end
        end_test();

        start_test("mem_backpressure");
        slow_mem = 1'b1;
        for (int i = 0; i < 12; i++) begin
            do_fetch(small_addr());
        end
        slow_mem = 1'b0;
        end_test();

        // about one flush in 32 operations
        start_test("random_mix");
        n_fetch = 0;
        while (n_fetch < 400 && !stuck) begin
            r = take_bits(5);
            if (r[4:0] == 5'd0) begin
                do_flush();
            end else begin
                do_fetch(small_addr());
                n_fetch++;
            end
        end
        end_test();

        errors = errors + i_icache_top.i_icache_properties.assert_fails;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, i_icache_top.i_icache_properties.assert_fails);
        if (errors == 0 && !stuck) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_way_select.sv
hw/icache_refill.sv
hw/icache_top.sv
tb/icache_properties.sv
tb/icache_tb.sv
